// File: rtl/conv_pkg.sv
package conv_pkg;

	// memory map, byte addresses
	localparam logic [31:0] ADDR_DIMS     = 32'h1000_0000;
	localparam logic [31:0] ADDR_START    = 32'h1000_0020;
	localparam logic [31:0] ADDR_FILTER   = 32'h1000_0040;
	localparam logic [31:0] ADDR_RESULT   = 32'h1000_0100;
	localparam logic [31:0] ADDR_STARTSIG = 32'h1000_0120;

	localparam int MAX_WIDTH  = 64;
	localparam int MAX_HEIGHT = 64;

	localparam int MEM_CREDITS = 4;
	localparam int TAG_DEPTH   = 16; // reads in flight, credits may return early

	localparam int COL_W  = $clog2(MAX_WIDTH);
	localparam int WORD_W = $clog2(MAX_WIDTH / 4);
	localparam int ROW_W  = $clog2(MAX_HEIGHT + 1);
	localparam int CRED_W = $clog2(MEM_CREDITS + 1);

	typedef logic signed [7:0] tap_t;

	// tap k sits at window row k/3, column k%3
	typedef tap_t [8:0] tap_array_t;

	typedef struct packed {
		logic [15:0] height;
		logic [15:0] width;
	} dims_t;

	typedef union packed {
		dims_t      dims_view;
		tap_t [3:0] taps_view; // lowest byte first
	} config_word_u;

	// client tags for the read return FIFO
	localparam logic [1:0] TAG_CFG   = 2'd0;
	localparam logic [1:0] TAG_FETCH = 2'd1;
	localparam logic [1:0] TAG_WR    = 2'd2;

endpackage

// File: rtl/mem_client_if.sv
`timescale 1ns/1ns

interface mem_client_if;

	logic        req;
	logic        we;
	logic [31:0] addr;
	logic [31:0] wdata;

	logic        accept; // same cycle as req
	logic        rvalid;
	logic [31:0] rdata;

	modport client (
		output req, we, addr, wdata,
		input  accept, rvalid, rdata
	);

	modport port (
		input  req, we, addr, wdata,
		output accept, rvalid, rdata
	);

endinterface

// File: rtl/conv_mem_port.sv
`timescale 1ns/1ns

module conv_mem_port (
	input  logic        clk,
	input  logic        rst_n,
	mem_client_if.port  cfg_m,
	mem_client_if.port  fetch_m,
	mem_client_if.port  wr_m,
	output logic        mem_req,
	output logic        mem_we,
	output logic [31:0] mem_addr,
	output logic [31:0] mem_wdata,
	input  logic        mem_credit,
	input  logic        mem_rvalid,
	input  logic [31:0] mem_rdata,
	output logic        all_credits
);
	import conv_pkg::*;

	logic [CRED_W-1:0] credits;
	logic              have_credit;
	logic [1:0]        tags [TAG_DEPTH];
	logic [$clog2(TAG_DEPTH)-1:0] wptr, rptr;
	logic [1:0]        rtag;

	assign have_credit = credits != '0;
	assign all_credits = credits == CRED_W'(MEM_CREDITS);

	// writer first, then fetch, then loader
	assign wr_m.accept    = have_credit && wr_m.req;
	assign fetch_m.accept = have_credit && fetch_m.req && !wr_m.req;
	assign cfg_m.accept   = have_credit && cfg_m.req && !wr_m.req && !fetch_m.req;

	assign mem_req = wr_m.accept || fetch_m.accept || cfg_m.accept;

	always_comb begin
		if (wr_m.req) begin
			mem_we    = wr_m.we;
			mem_addr  = wr_m.addr;
			mem_wdata = wr_m.wdata;
		end else if (fetch_m.req) begin
			mem_we    = fetch_m.we;
			mem_addr  = fetch_m.addr;
			mem_wdata = fetch_m.wdata;
		end else begin
			mem_we    = cfg_m.we;
			mem_addr  = cfg_m.addr;
			mem_wdata = cfg_m.wdata;
		end
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			credits <= CRED_W'(MEM_CREDITS);
		else
			credits <= credits - CRED_W'(mem_req) + CRED_W'(mem_credit);
	end

	// tag FIFO, one entry per read in flight
	always_ff @(posedge clk) begin
		if (mem_req && !mem_we)
			tags[wptr] <= wr_m.req ? TAG_WR : (fetch_m.req ? TAG_FETCH : TAG_CFG);
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (mem_req && !mem_we)
				wptr <= wptr + 1'b1;
			if (mem_rvalid)
				rptr <= rptr + 1'b1;
		end
	end

	assign rtag = tags[rptr];

	assign cfg_m.rvalid   = mem_rvalid && rtag == TAG_CFG;
	assign fetch_m.rvalid = mem_rvalid && rtag == TAG_FETCH;
	assign wr_m.rvalid    = mem_rvalid && rtag == TAG_WR;
	assign cfg_m.rdata    = mem_rdata;
	assign fetch_m.rdata  = mem_rdata;
	assign wr_m.rdata     = mem_rdata;

endmodule

// File: rtl/conv_config_loader.sv
`timescale 1ns/1ns

module conv_config_loader (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start_poll,
	mem_client_if.client         m,
	output logic                 config_done,
	output logic [15:0]          width,
	output logic [15:0]          height,
	output logic [31:0]          image_addr,
	output logic [31:0]          result_addr,
	output conv_pkg::tap_array_t taps
);
	import conv_pkg::*;

	typedef enum logic [2:0] {L_IDLE, L_POLL, L_POLL_WAIT, L_CLEAR, L_CFG, L_CFG_WAIT} lstate_e;
	lstate_e state;

	logic [2:0]   idx;
	config_word_u cw;

	assign cw = m.rdata;

	assign m.req   = state == L_POLL || state == L_CLEAR || state == L_CFG;
	assign m.we    = state == L_CLEAR;
	assign m.wdata = '0; // clears the start word

	always_comb begin
		case (state)
			L_POLL, L_CLEAR: m.addr = ADDR_STARTSIG;
			default: begin
				case (idx)
					3'd0:    m.addr = ADDR_DIMS;
					3'd1:    m.addr = ADDR_START;
					3'd2:    m.addr = ADDR_FILTER;
					3'd3:    m.addr = ADDR_FILTER + 32'd4;
					3'd4:    m.addr = ADDR_FILTER + 32'd8;
					default: m.addr = ADDR_RESULT;
				endcase
			end
		endcase
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state       <= L_IDLE;
			idx         <= '0;
			config_done <= 1'b0;
		end else begin
			config_done <= 1'b0;
			case (state)
				L_IDLE: if (start_poll) state <= L_POLL;
				L_POLL: if (m.accept) state <= L_POLL_WAIT;
				L_POLL_WAIT: begin
					if (m.rvalid) begin
						if (m.rdata == 32'd1) state <= L_CLEAR;
						else if (start_poll)  state <= L_POLL;
						else                  state <= L_IDLE;
					end
				end
				L_CLEAR: begin
					if (m.accept) begin
						idx   <= '0;
						state <= L_CFG;
					end
				end
				L_CFG: if (m.accept) state <= L_CFG_WAIT;
				L_CFG_WAIT: begin
					if (m.rvalid) begin
						idx <= idx + 1'b1;
						if (idx == 3'd5) begin
							config_done <= 1'b1;
							state       <= L_IDLE;
						end else begin
							state <= L_CFG;
						end
					end
				end
				default: state <= L_IDLE;
			endcase
		end
	end

	// decoded configuration, payload only
	always_ff @(posedge clk) begin
		if (state == L_CFG_WAIT && m.rvalid) begin
			case (idx)
				3'd0: begin
					width  <= cw.dims_view.width;
					height <= cw.dims_view.height;
				end
				3'd1: image_addr <= m.rdata;
				3'd2: taps[3:0] <= cw.taps_view;
				3'd3: taps[7:4] <= cw.taps_view;
				3'd4: taps[8]   <= cw.taps_view[0];
				default: result_addr <= m.rdata;
			endcase
		end
	end

endmodule

// File: rtl/conv_row_buffer.sv
`timescale 1ns/1ns

module conv_row_buffer (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [1:0]                fill_slot,
	input  logic                      fill_start,
	input  logic [31:0]               fill_addr,
	input  logic [15:0]               width,
	mem_client_if.client              m,
	output logic                      fill_done,
	input  logic [1:0]                top_slot,
	input  logic [conv_pkg::COL_W-1:0] col,
	input  logic                      shift_col,
	output logic [2:0][7:0]           col_pix
);
	import conv_pkg::*;

	logic [31:0]       words [4 * (MAX_WIDTH / 4)];
	logic              busy;
	logic [1:0]        slot;
	logic [31:0]       base;
	logic [WORD_W:0]   req_cnt, resp_cnt, total;
	logic [1:0]        rd_slot [3];
	logic [31:0]       rd_word [3];

	assign total = width[WORD_W+2:2];

	assign m.req   = busy && req_cnt != total;
	assign m.we    = 1'b0;
	assign m.addr  = base + {req_cnt, 2'b00};
	assign m.wdata = '0;

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			req_cnt   <= '0;
			resp_cnt  <= '0;
			fill_done <= 1'b0;
		end else begin
			fill_done <= 1'b0;
			if (fill_start) begin
				busy     <= 1'b1;
				req_cnt  <= '0;
				resp_cnt <= '0;
			end else if (busy) begin
				if (m.accept)
					req_cnt <= req_cnt + 1'b1;
				if (m.rvalid) begin
					resp_cnt <= resp_cnt + 1'b1;
					if (resp_cnt == total - 1'b1) begin
						busy      <= 1'b0;
						fill_done <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill_start) begin
			slot <= fill_slot;
			base <= fill_addr;
		end
	end

	always_ff @(posedge clk) begin
		if (busy && m.rvalid)
			words[{slot, resp_cnt[WORD_W-1:0]}] <= m.rdata;
	end

	// three consecutive slots, wrapping
	always_comb begin
		for (int i = 0; i < 3; i++) begin
			rd_slot[i] = top_slot + 2'(i);
			rd_word[i] = words[{rd_slot[i], col[COL_W-1:2]}];
		end
	end

	always_ff @(posedge clk) begin
		if (shift_col) begin
			for (int i = 0; i < 3; i++)
				col_pix[i] <= rd_word[i][8*col[1:0] +: 8];
		end
	end

endmodule

// File: rtl/conv_window_mac.sv
`timescale 1ns/1ns

module conv_window_mac (
	input  logic                 clk,
	input  logic                 rst_n,
	input  conv_pkg::tap_array_t taps,
	input  logic                 shift_col,
	input  logic [2:0][7:0]      col_pix,
	input  logic                 row_start,
	output logic                 out_valid,
	output logic [7:0]           out_pixel
);
	import conv_pkg::*;

	logic                shift_d; // pixels arrive one cycle after shift_col
	logic [1:0]          seen;
	logic [2:0][7:0]     c0, c1;
	logic signed [16:0]  prod [9];
	logic signed [20:0]  sum;

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			shift_d   <= 1'b0;
			seen      <= '0;
			out_valid <= 1'b0;
		end else begin
			shift_d   <= shift_col;
			out_valid <= shift_d && seen == 2'd2;
			if (row_start)
				seen <= '0;
			else if (shift_d && seen != 2'd2)
				seen <= seen + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (shift_d) begin
			c0 <= c1;
			c1 <= col_pix;
		end
	end

	// stage one, nine products with the incoming column as column 2
	always_ff @(posedge clk) begin
		if (shift_d) begin
			for (int r = 0; r < 3; r++) begin
				prod[3*r]     <= taps[3*r]     * $signed({1'b0, c0[r]});
				prod[3*r + 1] <= taps[3*r + 1] * $signed({1'b0, c1[r]});
				prod[3*r + 2] <= taps[3*r + 2] * $signed({1'b0, col_pix[r]});
			end
		end
	end

	// stage two, sum and clamp
	always_comb begin
		sum = '0;
		for (int k = 0; k < 9; k++)
			sum = sum + 21'(prod[k]);
		if (sum < 0)
			out_pixel = 8'd0;
		else if (sum > 21'sd255)
			out_pixel = 8'd255;
		else
			out_pixel = sum[7:0];
	end

endmodule

// File: rtl/conv_result_writer.sv
`timescale 1ns/1ns

module conv_result_writer (
	input  logic         clk,
	input  logic         rst_n,
	input  logic [31:0]  row_addr,
	input  logic         row_start,
	input  logic [15:0]  width,
	input  logic         out_valid,
	input  logic [7:0]   out_pixel,
	mem_client_if.client m,
	output logic         row_written
);
	import conv_pkg::*;

	logic [31:0]       words [MAX_WIDTH / 4];
	logic [31:0]       base;
	logic [23:0]       acc;
	logic [COL_W-1:0]  byte_cnt;
	logic [WORD_W:0]   fill_cnt, issue_cnt, total;
	logic              last_pix, word_full;

	assign total     = width[WORD_W+2:2];
	assign last_pix  = 16'(byte_cnt) == width - 16'd3;
	assign word_full = byte_cnt[1:0] == 2'd3 || last_pix;

	assign m.req   = issue_cnt != fill_cnt;
	assign m.we    = 1'b1;
	assign m.addr  = base + {issue_cnt, 2'b00};
	assign m.wdata = words[issue_cnt[WORD_W-1:0]];

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			byte_cnt    <= '0;
			fill_cnt    <= '0;
			issue_cnt   <= '0;
			row_written <= 1'b0;
		end else begin
			row_written <= 1'b0;
			if (row_start) begin
				byte_cnt  <= '0;
				fill_cnt  <= '0;
				issue_cnt <= '0;
			end else begin
				if (out_valid) begin
					byte_cnt <= byte_cnt + 1'b1;
					if (word_full)
						fill_cnt <= fill_cnt + 1'b1;
				end
				if (m.accept) begin
					issue_cnt <= issue_cnt + 1'b1;
					if (issue_cnt == total - 1'b1)
						row_written <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (row_start)
			base <= row_addr;
		if (out_valid) begin
			if (last_pix)
				words[fill_cnt[WORD_W-1:0]] <= {16'h0000, out_pixel, acc[7:0]}; // two pad bytes
			else if (word_full)
				words[fill_cnt[WORD_W-1:0]] <= {out_pixel, acc};
			else
				acc[8*byte_cnt[1:0] +: 8] <= out_pixel;
		end
	end

endmodule

// File: rtl/conv_controller.sv
`timescale 1ns/1ns

module conv_controller (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       config_done,
	input  logic [15:0]                width,
	input  logic [15:0]                height,
	input  logic [31:0]                image_addr,
	input  logic [31:0]                result_addr,
	input  logic                       fill_done,
	input  logic                       row_written,
	input  logic                       all_credits,
	output logic                       start_poll,
	output logic [1:0]                 fill_slot,
	output logic                       fill_start,
	output logic [31:0]                fill_addr,
	output logic [1:0]                 top_slot,
	output logic [conv_pkg::COL_W-1:0] col,
	output logic                       shift_col,
	output logic                       row_start,
	output logic [31:0]                row_addr,
	output logic                       done
);
	import conv_pkg::*;

	typedef enum logic [2:0] {IDLE, LOAD_CONFIG, FILL_FIRST, OPERATE, ROW_END, WAIT_FINAL,
		DONE} state_e;
	state_e state;

	logic [ROW_W-1:0] rows_left;
	logic [ROW_W-1:0] fetch_row;
	logic [31:0]      fetch_addr;
	logic             fill_pending, write_pending;
	logic             more_rows, row_clear;

	assign start_poll = state == LOAD_CONFIG;
	assign shift_col  = state == OPERATE;
	assign done       = state == DONE;

	assign more_rows = 16'(fetch_row) < height;
	assign row_clear = (!fill_pending || fill_done) && (!write_pending || row_written);

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state         <= IDLE;
			fill_start    <= 1'b0;
			row_start     <= 1'b0;
			fill_pending  <= 1'b0;
			write_pending <= 1'b0;
			rows_left     <= '0;
			fetch_row     <= '0;
			top_slot      <= '0;
			col           <= '0;
		end else begin
			fill_start <= 1'b0;
			row_start  <= 1'b0;
			if (fill_done)
				fill_pending <= 1'b0;
			if (row_written)
				write_pending <= 1'b0;

			case (state)
				IDLE: state <= LOAD_CONFIG;
				LOAD_CONFIG: begin
					if (config_done) begin
						fetch_addr   <= image_addr + 32'(width);
						fill_addr    <= image_addr;
						fill_slot    <= 2'd0;
						fill_start   <= 1'b1;
						fetch_row    <= ROW_W'(1);
						rows_left    <= ROW_W'(height - 16'd2);
						row_addr     <= result_addr;
						top_slot     <= '0;
						state        <= FILL_FIRST;
					end
				end
				FILL_FIRST: begin
					if (fill_done) begin
						if (fetch_row == ROW_W'(3)) begin
							state <= OPERATE;
						end else begin
							fill_start <= 1'b1;
							fill_slot  <= fetch_row[1:0];
							fill_addr  <= fetch_addr;
							fetch_addr <= fetch_addr + 32'(width);
							fetch_row  <= fetch_row + 1'b1;
						end
						if (fetch_row == ROW_W'(3)) begin
							row_start     <= 1'b1;
							write_pending <= 1'b1;
							col           <= '0;
							if (more_rows) begin
								fill_start   <= 1'b1;
								fill_pending <= 1'b1;
								fill_slot    <= fetch_row[1:0];
								fill_addr    <= fetch_addr;
								fetch_addr   <= fetch_addr + 32'(width);
								fetch_row    <= fetch_row + 1'b1;
							end
						end
					end
				end
				OPERATE: begin
					col <= col + 1'b1;
					if (16'(col) == width - 16'd1)
						state <= ROW_END;
				end
				ROW_END: begin
					if (row_clear) begin
						rows_left <= rows_left - 1'b1;
						if (rows_left == ROW_W'(1)) begin
							state <= WAIT_FINAL;
						end else begin
							state         <= OPERATE;
							top_slot      <= top_slot + 1'b1;
							row_addr      <= row_addr + 32'(width);
							row_start     <= 1'b1;
							write_pending <= 1'b1;
							col           <= '0;
							if (more_rows) begin // prefetch into the free slot
								fill_start   <= 1'b1;
								fill_pending <= 1'b1;
								fill_slot    <= fetch_row[1:0];
								fill_addr    <= fetch_addr;
								fetch_addr   <= fetch_addr + 32'(width);
								fetch_row    <= fetch_row + 1'b1;
							end
						end
					end
				end
				WAIT_FINAL: if (all_credits) state <= DONE;
				DONE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// File: rtl/conv_top.sv
`timescale 1ns/1ns

module conv_top (
	input  logic        clk,
	input  logic        rst_n,
	output logic        mem_req,
	output logic        mem_we,
	output logic [31:0] mem_addr,
	output logic [31:0] mem_wdata,
	input  logic        mem_credit,
	input  logic        mem_rvalid,
	input  logic [31:0] mem_rdata,
	output logic        done
);
	import conv_pkg::*;

	mem_client_if cfg_m ();
	mem_client_if fetch_m ();
	mem_client_if wr_m ();

	logic             all_credits, start_poll, config_done;
	logic [15:0]      width, height;
	logic [31:0]      image_addr, result_addr, fill_addr, row_addr;
	tap_array_t       taps;
	logic [1:0]       fill_slot, top_slot;
	logic             fill_start, fill_done, shift_col, row_start, row_written;
	logic [COL_W-1:0] col;
	logic [2:0][7:0]  col_pix;
	logic             out_valid;
	logic [7:0]       out_pixel;

	conv_mem_port u_port (.clk, .rst_n, .cfg_m(cfg_m.port), .fetch_m(fetch_m.port),
		.wr_m(wr_m.port), .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_credit,
		.mem_rvalid, .mem_rdata, .all_credits);

	conv_config_loader u_loader (.clk, .rst_n, .start_poll, .m(cfg_m.client), .config_done,
		.width, .height, .image_addr, .result_addr, .taps);

	conv_row_buffer u_rows (.clk, .rst_n, .fill_slot, .fill_start, .fill_addr, .width,
		.m(fetch_m.client), .fill_done, .top_slot, .col, .shift_col, .col_pix);

	conv_window_mac u_mac (.clk, .rst_n, .taps, .shift_col, .col_pix, .row_start,
		.out_valid, .out_pixel);

	conv_result_writer u_writer (.clk, .rst_n, .row_addr, .row_start, .width, .out_valid,
		.out_pixel, .m(wr_m.client), .row_written);

	conv_controller u_ctrl (.clk, .rst_n, .config_done, .width, .height, .image_addr,
		.result_addr, .fill_done, .row_written, .all_credits, .start_poll, .fill_slot,
		.fill_start, .fill_addr, .top_slot, .col, .shift_col, .row_start, .row_addr, .done);

endmodule

// File: bench/conv_tb.sv
`timescale 1ns/1ns

module conv_tb;
	import conv_pkg::*;

	logic        clk;
	logic        rst_n;
	logic        mem_req;
	logic        mem_we;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic        mem_credit = 1'b0;
	logic        mem_rvalid = 1'b0;
	logic [31:0] mem_rdata  = '0;
	logic        done;

	logic [31:0] mem_words [logic [31:0]]; // sparse, keyed by word address
	int          rd_due [$];
	logic [31:0] rd_data [$];

	logic [7:0]  img [MAX_HEIGHT][MAX_WIDTH];
	int          taps_ref [9];
	int          img_w, img_h;
	logic [31:0] res_base;

	int checks, mismatches, other_errors;
	int low_clamps, high_clamps;
	int cycle, last_due, owed, peak_owed, stall_left;
	int done_count;
	bit armed, timed_out;

	conv_top dut_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.mem_req    (mem_req),
		.mem_we     (mem_we),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_credit (mem_credit),
		.mem_rvalid (mem_rvalid),
		.mem_rdata  (mem_rdata),
		.done       (done)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] read_word(input logic [31:0] addr);
		logic [31:0] a;
		a = {addr[31:2], 2'b00};
		if (mem_words.exists(a))
			return mem_words[a];
		return 32'h0;
	endfunction

	function automatic logic [7:0] byte_at(input logic [31:0] addr);
		logic [31:0] word;
		word = read_word(addr);
		return word[8 * addr[1:0] +: 8];
	endfunction

	// clamped 3x3 sum, tap k at row k/3 and column k%3
	function automatic logic [7:0] expected_pixel(input int r, input int c);
		int sum;
		sum = 0;
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++)
				sum += taps_ref[3 * i + j] * int'(img[r + i][c + j]);
		end
		if (sum < 0) begin
			low_clamps++;
			return 8'd0;
		end
		if (sum > 255) begin
			high_clamps++;
			return 8'd255;
		end
		return 8'(sum);
	endfunction

	task automatic store_word(input logic [31:0] addr, input logic [31:0] data);
		logic [31:0] a;
		a = {addr[31:2], 2'b00};
		checks++;
		if (a == ADDR_STARTSIG) begin
			assert (armed && data == 32'h0) else begin
				other_errors++;
				$display("start word written with %h at %0t outside a run", data, $time);
			end
		end else begin
			assert (armed && a >= res_base && a < res_base + 32'(img_w * (img_h - 2))) else begin
				other_errors++;
				$display("write to %h at %0t falls outside the result region", a, $time);
			end
		end
		mem_words[a] = data;
	endtask

	// memory model, samples requests and drives responses on the falling edge
	always @(negedge clk) begin
		bit pulse;
		int due;
		if (!rst_n) begin
			mem_credit = 1'b0;
			mem_rvalid = 1'b0;
			owed       = 0;
			rd_due.delete();
			rd_data.delete();
		end else begin
			cycle++;
			checks++;
			assert (!done || armed) else begin
				other_errors++;
				$display("done pulsed at %0t without a run in progress", $time);
			end
			if (done) begin
				done_count++;
				armed = 1'b0;
			end

			if (stall_left > 0)
				stall_left--;
			else if ($urandom_range(199) == 0)
				stall_left = $urandom_range(80, 20); // credit return held back
			pulse = owed > 0 && stall_left == 0 && $urandom_range(2) != 0;

			if (mem_req) begin
				checks++;
				assert (owed < MEM_CREDITS) else begin
					other_errors++;
					$display("more than %0d requests outstanding at %0t", MEM_CREDITS, $time);
				end
				owed++;
				if (owed > peak_owed)
					peak_owed = owed;
				if (mem_we) begin
					store_word(mem_addr, mem_wdata);
				end else begin
					due = cycle + $urandom_range(6, 1);
					if (due <= last_due)
						due = last_due + 1; // keep responses in order
					last_due = due;
					rd_due.push_back(due);
					rd_data.push_back(read_word(mem_addr));
				end
			end

			if (pulse)
				owed--;
			mem_credit = pulse;
			mem_rvalid = 1'b0;
			if (rd_due.size() > 0 && rd_due[0] <= cycle) begin
				mem_rvalid = 1'b1;
				mem_rdata  = rd_data.pop_front();
				void'(rd_due.pop_front());
			end
		end
	end

	task automatic check_results(input int run);
		logic [31:0] row;
		logic [7:0]  got, want;
		checks++;
		assert (done_count == 1) else begin
			other_errors++;
			$display("done pulsed %0d times in run %0d", done_count, run);
		end
		checks++;
		assert (read_word(ADDR_STARTSIG) == 32'h0) else begin
			other_errors++;
			$display("start word reads back %h after run %0d", read_word(ADDR_STARTSIG), run);
		end
		for (int r = 0; r < img_h - 2; r++) begin
			row = res_base + 32'(r * img_w);
			for (int c = 0; c < img_w; c++) begin
				got  = byte_at(row + 32'(c));
				want = (c < img_w - 2) ? expected_pixel(r, c) : 8'h00; // two pad bytes
				checks++;
				assert (got == want) else begin
					mismatches++;
					$display("mismatch at %0t: result_byte[%0d][%0d] run %0d got %02h expected %02h",
						$time, r, c, run, got, want);
				end
			end
		end
	endtask

	task automatic run_image(input int run);
		logic [31:0] img_base;
		int          limit;
		img_w    = 4 * $urandom_range(MAX_WIDTH / 4, 2);
		img_h    = $urandom_range(MAX_HEIGHT, 3);
		img_base = 32'h0000_2000 + 32'(run) * 32'h0000_1400;
		res_base = 32'h0000_8000 + 32'(run) * 32'h0000_0100;

		for (int k = 0; k < 9; k++) begin
			if (run == 0)
				taps_ref[k] = int'($urandom_range(255)) - 128;
			else
				taps_ref[k] = int'($urandom_range(40)) - 20;
		end
		for (int r = 0; r < img_h; r++) begin
			for (int c = 0; c < img_w; c++)
				img[r][c] = 8'($urandom_range(255));
		end
		for (int r = 0; r < img_h; r++) begin
			for (int c = 0; c < img_w; c += 4)
				mem_words[img_base + 32'(r * img_w + c)] =
					{img[r][c + 3], img[r][c + 2], img[r][c + 1], img[r][c]};
		end
		for (int a = 0; a < img_w * (img_h - 2); a += 4)
			mem_words[res_base + 32'(a)] = (res_base + 32'(a)) ^ 32'hC3C3_5A5A;

		mem_words[ADDR_DIMS]   = {16'(img_h), 16'(img_w)};
		mem_words[ADDR_START]  = img_base;
		mem_words[ADDR_FILTER] = {8'(taps_ref[3]), 8'(taps_ref[2]), 8'(taps_ref[1]),
			8'(taps_ref[0])};
		mem_words[ADDR_FILTER + 32'd4] = {8'(taps_ref[7]), 8'(taps_ref[6]), 8'(taps_ref[5]),
			8'(taps_ref[4])};
		mem_words[ADDR_FILTER + 32'd8] = {24'h0, 8'(taps_ref[8])};
		mem_words[ADDR_RESULT] = res_base;

		repeat ($urandom_range(150, 40)) @(posedge clk); // DUT keeps polling a zero start word

		done_count = 0;
		armed      = 1'b1;
		mem_words[ADDR_STARTSIG] = 32'd1;
		limit = 0;
		while (done_count == 0 && limit < 300000) begin
			@(posedge clk);
			limit++;
		end
		checks++;
		assert (done_count > 0) else begin
			other_errors++;
			timed_out = 1'b1;
			$display("run %0d timed out waiting for done", run);
		end
		if (!timed_out) begin
			repeat (40) @(posedge clk);
			check_results(run);
		end
	endtask

	initial begin
		void'($urandom(82522));
		rst_n = 1'b0;
		repeat (4) @(negedge clk);
		rst_n <= 1'b1;

		for (int run = 0; run < 3 && !timed_out; run++)
			run_image(run);

		checks++;
		assert (timed_out || (low_clamps > 0 && high_clamps > 0)) else begin
			other_errors++;
			$display("the images never pushed a sum past both clamp limits");
		end
		checks++;
		assert (timed_out || peak_owed == MEM_CREDITS) else begin
			other_errors++;
			$display("outstanding requests never reached the credit limit");
		end

		$display("checks %0d, mismatches %0d, other errors %0d, peak outstanding %0d",
			checks, mismatches, other_errors, peak_owed);
		if (mismatches + other_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: project.f
rtl/conv_pkg.sv
rtl/mem_client_if.sv
rtl/conv_mem_port.sv
rtl/conv_config_loader.sv
rtl/conv_row_buffer.sv
rtl/conv_window_mac.sv
rtl/conv_result_writer.sv
rtl/conv_controller.sv
rtl/conv_top.sv
bench/conv_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module conv_tb -f project.f -o conv_sim \
	&& ./obj_dir/conv_sim > sim.log 2>&1 \
	|| { echo "build or simulation failed"; exit 1; }

grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
